/* design/rob_cfg_pkg.sv */
package rob_cfg_pkg;

  // buffer geometry
  localparam int rob_depth       = 8;
  localparam int rob_index_width = 3;

  // slot number inside the circular queue
  typedef logic [rob_index_width-1:0] rob_index_t;

  // slot number with a wrap bit on top
  // equal pointers mean empty, a difference in the wrap bit alone means full
  typedef logic [rob_index_width:0] rob_ptr_t;

endpackage

/* design/rob_entry_pkg.sv */
package rob_entry_pkg;

  localparam int addr_width     = 32;
  localparam int data_width     = 32;
  localparam int reg_addr_width = 5;
  localparam int exc_code_width = 5;

  typedef logic [addr_width-1:0]     addr_t;
  typedef logic [data_width-1:0]     data_t;
  typedef logic [reg_addr_width-1:0] reg_addr_t;
  typedef logic [exc_code_width-1:0] exc_code_t;

  // one instruction record, 76 bits
  typedef struct packed {
    logic      done;
    logic      reg_write_en;
    reg_addr_t reg_addr;
    data_t     result;
    exc_code_t exc_code;
    addr_t     pc;
  } rob_entry_t;

endpackage

/* design/rob_ptr_if.sv */
`timescale 1ns/1ps

interface rob_ptr_if;

  // resolved write strobe, allocate or update
  logic                   wr_en;
  rob_cfg_pkg::rob_index_t wr_index;

  // read slots for the two views
  rob_cfg_pkg::rob_index_t issue_index;
  rob_cfg_pkg::rob_index_t commit_index;

  // done bit of the head slot
  logic                   head_done;

  modport ctrl (
    output wr_en,
    output wr_index,
    output issue_index,
    output commit_index,
    input  head_done
  );

  modport array (
    input  wr_en,
    input  wr_index,
    input  issue_index,
    input  commit_index,
    output head_done
  );

endinterface

/* design/rob_ptr_ctrl.sv */
`timescale 1ns/1ps

module rob_ptr_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    write_en,
  input  logic                    read_en,
  input  logic                    commit_en,
  input  logic                    update_en,
  input  logic                    erase_en,
  input  rob_cfg_pkg::rob_index_t update_addr,
  input  rob_cfg_pkg::rob_index_t erase_addr,
  output logic                    can_write,
  output logic                    can_read,
  output logic                    can_commit,
  output rob_cfg_pkg::rob_index_t issue_tag,
  output rob_cfg_pkg::rob_index_t commit_tag,
  rob_ptr_if.ctrl                 ptr
);

  localparam int iw = rob_cfg_pkg::rob_index_width;

  rob_cfg_pkg::rob_ptr_t head_ptr;
  rob_cfg_pkg::rob_ptr_t read_ptr;
  rob_cfg_pkg::rob_ptr_t tail_ptr;

  logic empty;
  logic full;
  logic do_alloc;
  logic do_read;
  logic do_commit;

  rob_cfg_pkg::rob_ptr_t read_next;
  rob_cfg_pkg::rob_ptr_t erase_tail;
  rob_cfg_pkg::rob_ptr_t erase_count;
  rob_cfg_pkg::rob_ptr_t read_dist;
  logic                  erase_wrap;
  logic                  pull_back;

  // status flags
  assign empty      = head_ptr == tail_ptr;
  assign full       = (head_ptr[iw-1:0] == tail_ptr[iw-1:0]) && (head_ptr[iw] != tail_ptr[iw]);
  assign can_write  = !full;
  assign can_read   = read_ptr != tail_ptr;
  assign can_commit = !empty && ptr.head_done;

  // enables only count while their flag is up
  assign do_alloc  = write_en && can_write && !erase_en;
  assign do_read   = read_en && can_read;
  assign do_commit = commit_en && can_commit;

  // allocate beats update, erase blocks allocate
  assign ptr.wr_en    = do_alloc || update_en;
  assign ptr.wr_index = do_alloc ? tail_ptr[iw-1:0] : update_addr;

  assign ptr.issue_index  = read_ptr[iw-1:0];
  assign ptr.commit_index = head_ptr[iw-1:0];
  assign issue_tag        = read_ptr[iw-1:0];
  assign commit_tag       = head_ptr[iw-1:0];

  // new tail after erase, wrap taken relative to head
  always_comb begin
    erase_wrap  = (erase_addr >= head_ptr[iw-1:0]) ? head_ptr[iw] : !head_ptr[iw];
    erase_tail  = {erase_wrap, erase_addr};
    erase_count = erase_tail - head_ptr;
    read_next   = read_ptr + rob_cfg_pkg::rob_ptr_t'(do_read);
    read_dist   = read_next - head_ptr;
    // read pointer beyond the cut gets pulled back to it
    pull_back   = read_dist > erase_count;
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      head_ptr <= '0;
    end else if (do_commit) begin
      head_ptr <= head_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      read_ptr <= '0;
    end else if (erase_en && pull_back) begin
      read_ptr <= erase_tail;
    end else begin
      read_ptr <= read_next;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      tail_ptr <= '0;
    end else if (erase_en) begin
      tail_ptr <= erase_tail;
    end else if (do_alloc) begin
      tail_ptr <= tail_ptr + 1'b1;
    end
  end

endmodule

/* design/rob_entry_array.sv */
`timescale 1ns/1ps

module rob_entry_array (
  input  logic                      clk,
  input  logic                      rst,
  input  rob_entry_pkg::rob_entry_t wr_data,
  output rob_entry_pkg::rob_entry_t issue_entry,
  output rob_entry_pkg::rob_entry_t commit_entry,
  rob_ptr_if.array                  ptr
);

  rob_entry_pkg::rob_entry_t entries [rob_cfg_pkg::rob_depth];

  // single write port, shared by allocate and update
  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < rob_cfg_pkg::rob_depth; i++) begin
        entries[i] <= '0;
      end
    end else if (ptr.wr_en) begin
      entries[ptr.wr_index] <= wr_data;
    end
  end

  // combinational views
  assign issue_entry  = entries[ptr.issue_index];
  assign commit_entry = entries[ptr.commit_index];

  // head done bit goes back for the commit flag
  assign ptr.head_done = commit_entry.done;

endmodule

/* design/rob_top.sv */
`timescale 1ns/1ps

module rob_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     write_en,
  input  logic                     read_en,
  input  logic                     update_en,
  input  logic                     commit_en,
  input  logic                     erase_en,
  input  rob_cfg_pkg::rob_index_t  update_addr,
  input  rob_cfg_pkg::rob_index_t  erase_addr,
  input  logic                     in_done,
  input  logic                     in_reg_write_en,
  input  rob_entry_pkg::reg_addr_t in_reg_addr,
  input  rob_entry_pkg::data_t     in_result,
  input  rob_entry_pkg::exc_code_t in_exc_code,
  input  rob_entry_pkg::addr_t     in_pc,
  output logic                     can_write,
  output logic                     can_read,
  output logic                     can_commit,
  output rob_cfg_pkg::rob_index_t  issue_tag,
  output rob_entry_pkg::addr_t     issue_pc,
  output rob_entry_pkg::exc_code_t issue_exc_code,
  output rob_cfg_pkg::rob_index_t  commit_tag,
  output logic                     commit_reg_write_en,
  output rob_entry_pkg::reg_addr_t commit_reg_addr,
  output rob_entry_pkg::data_t     commit_result,
  output rob_entry_pkg::exc_code_t commit_exc_code,
  output rob_entry_pkg::addr_t     commit_pc
);

  rob_entry_pkg::rob_entry_t wr_data;
  rob_entry_pkg::rob_entry_t issue_entry;
  rob_entry_pkg::rob_entry_t commit_entry;

  rob_ptr_if u_ptr_if ();

  // pack incoming record
  assign wr_data.done         = in_done;
  assign wr_data.reg_write_en = in_reg_write_en;
  assign wr_data.reg_addr     = in_reg_addr;
  assign wr_data.result       = in_result;
  assign wr_data.exc_code     = in_exc_code;
  assign wr_data.pc           = in_pc;

  rob_ptr_ctrl u_ptr_ctrl (
    .clk         (clk),
    .rst         (rst),
    .write_en    (write_en),
    .read_en     (read_en),
    .commit_en   (commit_en),
    .update_en   (update_en),
    .erase_en    (erase_en),
    .update_addr (update_addr),
    .erase_addr  (erase_addr),
    .can_write   (can_write),
    .can_read    (can_read),
    .can_commit  (can_commit),
    .issue_tag   (issue_tag),
    .commit_tag  (commit_tag),
    .ptr         (u_ptr_if.ctrl)
  );

  rob_entry_array u_entry_array (
    .clk          (clk),
    .rst          (rst),
    .wr_data      (wr_data),
    .issue_entry  (issue_entry),
    .commit_entry (commit_entry),
    .ptr          (u_ptr_if.array)
  );

  // issue view
  assign issue_pc       = issue_entry.pc;
  assign issue_exc_code = issue_entry.exc_code;

  // commit view
  assign commit_reg_write_en = commit_entry.reg_write_en;
  assign commit_reg_addr     = commit_entry.reg_addr;
  assign commit_result       = commit_entry.result;
  assign commit_exc_code     = commit_entry.exc_code;
  assign commit_pc           = commit_entry.pc;

endmodule

/* test/tb_rob.sv */
`timescale 1ns/1ps

module tb_rob;

  // data file layout, one row per cycle
  localparam int cols            = 17;
  localparam int max_rows        = 64;
  localparam int col_test        = 0;
  localparam int col_last        = 1;
  localparam int col_en          = 2;
  localparam int col_update_addr = 3;
  localparam int col_erase_addr  = 4;
  localparam int col_done        = 5;
  localparam int col_reg_wr      = 6;
  localparam int col_reg_addr    = 7;
  localparam int col_result      = 8;
  localparam int col_exc_code    = 9;
  localparam int col_pc          = 10;
  localparam int col_flags       = 11;
  localparam int col_issue_pc    = 12;
  localparam int col_commit_pc   = 13;
  localparam int col_commit_res  = 14;
  localparam int col_commit_reg  = 15;
  localparam int col_mask        = 16;
  localparam logic [31:0] no_row = 32'hffff_ffff;

  logic                     clk;
  logic                     rst;
  logic                     write_en;
  logic                     read_en;
  logic                     update_en;
  logic                     commit_en;
  logic                     erase_en;
  rob_cfg_pkg::rob_index_t  update_addr;
  rob_cfg_pkg::rob_index_t  erase_addr;
  logic                     in_done;
  logic                     in_reg_write_en;
  rob_entry_pkg::reg_addr_t in_reg_addr;
  rob_entry_pkg::data_t     in_result;
  rob_entry_pkg::exc_code_t in_exc_code;
  rob_entry_pkg::addr_t     in_pc;
  logic                     can_write;
  logic                     can_read;
  logic                     can_commit;
  rob_cfg_pkg::rob_index_t  issue_tag;
  rob_entry_pkg::addr_t     issue_pc;
  rob_entry_pkg::exc_code_t issue_exc_code;
  rob_cfg_pkg::rob_index_t  commit_tag;
  logic                     commit_reg_write_en;
  rob_entry_pkg::reg_addr_t commit_reg_addr;
  rob_entry_pkg::data_t     commit_result;
  rob_entry_pkg::exc_code_t commit_exc_code;
  rob_entry_pkg::addr_t     commit_pc;

  logic [31:0] vectors [max_rows*cols];

  // expected pointer positions, counted without wrap
  int exp_head;
  int exp_read;
  int exp_tail;

  // expected fields that the data file does not list
  logic                     model_reg_wr [rob_cfg_pkg::rob_depth];
  rob_entry_pkg::exc_code_t model_exc    [rob_cfg_pkg::rob_depth];

  int num_rows;
  int cycle_count;
  int cycle_limit = 0;
  int errors;
  int test_errors;
  int tests_run;
  int tests_failed;

  rob_top u_dut (
    .clk                 (clk),
    .rst                 (rst),
    .write_en            (write_en),
    .read_en             (read_en),
    .update_en           (update_en),
    .commit_en           (commit_en),
    .erase_en            (erase_en),
    .update_addr         (update_addr),
    .erase_addr          (erase_addr),
    .in_done             (in_done),
    .in_reg_write_en     (in_reg_write_en),
    .in_reg_addr         (in_reg_addr),
    .in_result           (in_result),
    .in_exc_code         (in_exc_code),
    .in_pc               (in_pc),
    .can_write           (can_write),
    .can_read            (can_read),
    .can_commit          (can_commit),
    .issue_tag           (issue_tag),
    .issue_pc            (issue_pc),
    .issue_exc_code      (issue_exc_code),
    .commit_tag          (commit_tag),
    .commit_reg_write_en (commit_reg_write_en),
    .commit_reg_addr     (commit_reg_addr),
    .commit_result       (commit_result),
    .commit_exc_code     (commit_exc_code),
    .commit_pc           (commit_pc)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] vec_word(input int row, input int col);
    return vectors[row*cols + col];
  endfunction

  task automatic count_failure();
    errors++;
    test_errors++;
  endtask

  task automatic drive_row(input int row);
    logic [31:0] en;
    logic [31:0] word;
    en          = vec_word(row, col_en);
    write_en    = en[4];
    read_en     = en[3];
    update_en   = en[2];
    commit_en   = en[1];
    erase_en    = en[0];
    update_addr = rob_cfg_pkg::rob_index_t'(vec_word(row, col_update_addr));
    erase_addr  = rob_cfg_pkg::rob_index_t'(vec_word(row, col_erase_addr));
    word        = vec_word(row, col_done);
    in_done     = word[0];
    word        = vec_word(row, col_reg_wr);
    in_reg_write_en = word[0];
    in_reg_addr = rob_entry_pkg::reg_addr_t'(vec_word(row, col_reg_addr));
    in_result   = vec_word(row, col_result);
    in_exc_code = rob_entry_pkg::exc_code_t'(vec_word(row, col_exc_code));
    in_pc       = vec_word(row, col_pc);
  endtask

  task automatic check_row(input int row);
    logic [31:0] mask;
    logic [31:0] flags;
    logic [31:0] exp_word;
    rob_entry_pkg::reg_addr_t exp_reg;
    rob_cfg_pkg::rob_index_t  issue_slot;
    rob_cfg_pkg::rob_index_t  commit_slot;
    int test_id;
    mask        = vec_word(row, col_mask);
    flags       = vec_word(row, col_flags);
    test_id     = int'(vec_word(row, col_test));
    issue_slot  = rob_cfg_pkg::rob_index_t'(exp_read % rob_cfg_pkg::rob_depth);
    commit_slot = rob_cfg_pkg::rob_index_t'(exp_head % rob_cfg_pkg::rob_depth);
    if (mask[0]) begin
      if (can_write !== flags[2]) begin
        $display("CHECK FAILED test %0d row %0d: can_write expected %h got %h",
                 test_id, row + 1, flags[2], can_write);
        count_failure();
      end
      if (can_read !== flags[1]) begin
        $display("CHECK FAILED test %0d row %0d: can_read expected %h got %h",
                 test_id, row + 1, flags[1], can_read);
        count_failure();
      end
      if (can_commit !== flags[0]) begin
        $display("CHECK FAILED test %0d row %0d: can_commit expected %h got %h",
                 test_id, row + 1, flags[0], can_commit);
        count_failure();
      end
      if (issue_tag !== issue_slot) begin
        $display("CHECK FAILED test %0d row %0d: issue_tag expected %h got %h",
                 test_id, row + 1, issue_slot, issue_tag);
        count_failure();
      end
      if (commit_tag !== commit_slot) begin
        $display("CHECK FAILED test %0d row %0d: commit_tag expected %h got %h",
                 test_id, row + 1, commit_slot, commit_tag);
        count_failure();
      end
    end
    exp_word = vec_word(row, col_issue_pc);
    if (mask[1] && issue_pc !== exp_word) begin
      $display("CHECK FAILED test %0d row %0d: issue_pc expected %h got %h",
               test_id, row + 1, exp_word, issue_pc);
      count_failure();
    end
    if (mask[1] && issue_exc_code !== model_exc[issue_slot]) begin
      $display("CHECK FAILED test %0d row %0d: issue_exc_code expected %h got %h",
               test_id, row + 1, model_exc[issue_slot], issue_exc_code);
      count_failure();
    end
    exp_word = vec_word(row, col_commit_pc);
    if (mask[2] && commit_pc !== exp_word) begin
      $display("CHECK FAILED test %0d row %0d: commit_pc expected %h got %h",
               test_id, row + 1, exp_word, commit_pc);
      count_failure();
    end
    if (mask[2] && commit_exc_code !== model_exc[commit_slot]) begin
      $display("CHECK FAILED test %0d row %0d: commit_exc_code expected %h got %h",
               test_id, row + 1, model_exc[commit_slot], commit_exc_code);
      count_failure();
    end
    if (mask[2] && commit_reg_write_en !== model_reg_wr[commit_slot]) begin
      $display("CHECK FAILED test %0d row %0d: commit_reg_write_en expected %h got %h",
               test_id, row + 1, model_reg_wr[commit_slot], commit_reg_write_en);
      count_failure();
    end
    exp_word = vec_word(row, col_commit_res);
    if (mask[3] && commit_result !== exp_word) begin
      $display("CHECK FAILED test %0d row %0d: commit_result expected %h got %h",
               test_id, row + 1, exp_word, commit_result);
      count_failure();
    end
    exp_reg = rob_entry_pkg::reg_addr_t'(vec_word(row, col_commit_reg));
    if (mask[4] && commit_reg_addr !== exp_reg) begin
      $display("CHECK FAILED test %0d row %0d: commit_reg_addr expected %h got %h",
               test_id, row + 1, exp_reg, commit_reg_addr);
      count_failure();
    end
  endtask

  // steps the expected state across the row's edge
  task automatic advance_model(input int row);
    logic [31:0] flags;
    logic        alloc;
    int          slot;
    int          count;
    flags = vec_word(row, col_flags);
    alloc = write_en && flags[2] && !erase_en;
    slot  = -1;
    // allocate takes the single write port first
    if (alloc) begin
      slot = exp_tail % rob_cfg_pkg::rob_depth;
    end else if (update_en) begin
      slot = int'(update_addr);
    end
    if (slot >= 0) begin
      model_reg_wr[slot] = in_reg_write_en;
      model_exc[slot]    = in_exc_code;
    end
    if (read_en && flags[1]) begin
      exp_read++;
    end
    if (erase_en) begin
      // entries kept behind the head
      count = (int'(erase_addr) - exp_head % rob_cfg_pkg::rob_depth
               + rob_cfg_pkg::rob_depth) % rob_cfg_pkg::rob_depth;
      if (exp_read - exp_head > count) begin
        exp_read = exp_head + count;
      end
      exp_tail = exp_head + count;
    end else if (alloc) begin
      exp_tail++;
    end
    if (commit_en && flags[0]) begin
      exp_head++;
    end
  endtask

  task automatic report_test(input int test_id);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d passed", test_id);
    end else begin
      tests_failed++;
      $display("test %0d failed with %0d errors", test_id, test_errors);
    end
    test_errors = 0;
  endtask

  // stops a replay that runs past its length
  initial begin : watchdog
    cycle_count = 0;
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: replay did not finish within %0d cycles", cycle_limit);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    rst             = 1'b0;
    write_en        = 1'b0;
    read_en         = 1'b0;
    update_en       = 1'b0;
    commit_en       = 1'b0;
    erase_en        = 1'b0;
    update_addr     = '0;
    erase_addr      = '0;
    in_done         = 1'b0;
    in_reg_write_en = 1'b0;
    in_reg_addr     = '0;
    in_result       = '0;
    in_exc_code     = '0;
    in_pc           = '0;
    errors          = 0;
    test_errors     = 0;
    tests_run       = 0;
    tests_failed    = 0;
    exp_head        = 0;
    exp_read        = 0;
    exp_tail        = 0;

    // storage comes out of reset cleared
    for (int i = 0; i < rob_cfg_pkg::rob_depth; i++) begin
      model_reg_wr[i] = 1'b0;
      model_exc[i]    = '0;
    end

    // unused rows keep the marker, so the row count falls out
    for (int i = 0; i < max_rows*cols; i++) begin
      vectors[i] = no_row;
    end
    $readmemh("test/rob_tests.mem", vectors);
    num_rows = 0;
    while (num_rows < max_rows && vectors[num_rows*cols] != no_row) begin
      num_rows++;
    end
    if (num_rows == 0) begin
      $display("no stimulus rows found in test/rob_tests.mem");
      errors++;
    end
    cycle_limit = 2*num_rows + 20;

    repeat (3) @(posedge clk);
    #1;
    rst = 1'b1;

    // expected values describe the state seen before the row's edge
    for (int row = 0; row < num_rows; row++) begin
      drive_row(row);
      #2;
      check_row(row);
      advance_model(row);
      if (vec_word(row, col_last) != 0) begin
        report_test(int'(vec_word(row, col_test)));
      end
      @(posedge clk);
      #1;
    end

    $display("%0d tests run, %0d passed, %0d failed, %0d failed checks",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* test/rob_tests.mem */
// test last en(wr rd up cm er) upd_addr ers_addr done reg_wr reg result exc pc
// expect: flags(cw cr cc) issue_pc commit_pc commit_result commit_reg, then check mask
// expected values are the state seen while the row is driven, before its edge
01 0 10 0 0 0 1 01 a0 00 100  4 000 000 00 00 1f
01 0 10 0 0 0 1 02 a1 00 104  6 100 100 a0 01 1f
01 0 10 0 0 0 1 03 a2 00 108  6 100 100 a0 01 1f
01 0 10 0 0 0 1 04 a3 00 10c  6 100 100 a0 01 1f
01 0 10 0 0 0 1 05 a4 00 110  6 100 100 a0 01 1f
01 0 10 0 0 0 1 06 a5 00 114  6 100 100 a0 01 1f
01 0 10 0 0 0 1 07 a6 00 118  6 100 100 a0 01 1f
01 0 10 0 0 0 1 08 a7 00 11c  6 100 100 a0 01 1f
01 0 10 0 0 0 1 1f ff 03 120  2 100 100 a0 01 1f
01 1 00 0 0 0 0 00 00 00 000  2 100 100 a0 01 1f

02 0 08 0 0 0 0 00 00 00 000  2 100 100 a0 01 1f
02 0 08 0 0 0 0 00 00 00 000  2 104 100 a0 01 1f
02 0 08 0 0 0 0 00 00 00 000  2 108 100 a0 01 1f
02 0 08 0 0 0 0 00 00 00 000  2 10c 100 a0 01 1f
02 0 08 0 0 0 0 00 00 00 000  2 110 100 a0 01 1f
02 0 08 0 0 0 0 00 00 00 000  2 114 100 a0 01 1f
02 0 08 0 0 0 0 00 00 00 000  2 118 100 a0 01 1f
02 0 08 0 0 0 0 00 00 00 000  2 11c 100 a0 01 1f
02 1 00 0 0 0 0 00 00 00 000  0 100 100 a0 01 1f

03 0 04 2 0 1 1 03 b2 00 108  0 100 100 a0 01 1f
03 0 00 0 0 0 0 00 00 00 000  0 100 100 a0 01 1f
03 0 04 0 0 1 1 01 b0 00 100  0 100 100 a0 01 1f
03 1 00 0 0 0 0 00 00 00 000  1 100 100 b0 01 1f

04 0 02 0 0 0 0 00 00 00 000  1 100 100 b0 01 1f
04 0 04 1 0 1 1 02 b1 00 104  4 100 104 a1 02 1f
04 0 02 0 0 0 0 00 00 00 000  5 100 104 b1 02 1f
04 0 02 0 0 0 0 00 00 00 000  5 100 108 b2 03 1f
04 1 00 0 0 0 0 00 00 00 000  4 100 10c a3 04 1f

05 0 01 0 5 0 0 00 00 00 000  4 100 10c a3 04 1f
05 0 10 0 0 0 1 09 c5 00 200  4 114 10c a3 04 1f
05 1 00 0 0 0 0 00 00 00 000  6 200 10c a3 04 1f

06 0 14 3 0 1 1 0a d6 00 300  6 200 10c a3 04 1f
06 0 08 0 0 0 0 00 00 00 000  6 200 10c a3 04 1f
06 0 11 0 4 0 1 0b e7 00 400  6 300 10c a3 04 1f
06 1 00 0 0 0 0 00 00 00 000  4 110 10c a3 04 1f

/* verilog.f */
design/rob_cfg_pkg.sv
design/rob_entry_pkg.sv
design/rob_ptr_if.sv
design/rob_ptr_ctrl.sv
design/rob_entry_array.sv
design/rob_top.sv
test/tb_rob.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_rob -f verilog.f -o sim_rob
./obj_dir/sim_rob | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  exit 0
else
  exit 1
fi
